// ==== src/ex_config.svh ====
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Data path width of the execute stage
`define EX_XLEN 32

// Register file write address width
// Covers the integer and the extended register space
`define EX_RF_AW 6

// Cycles a high-word multiply keeps the multiplier busy
// One partial product is accumulated per cycle
`define EX_MULH_CYCLES 4

// Operand width of one partial product
// Two halves make one data word
`define EX_PP_W 16

`endif

// ==== src/ex_rf_pkg.sv ====
`include "ex_config.svh"

package ex_rf_pkg;

  // One data word as read from or written to the register file
  typedef logic [`EX_XLEN-1:0] word_t;

  // Double word, full width of a product
  typedef logic [2*`EX_XLEN-1:0] dword_t;

  // Register file write address
  // Upper bit selects the extended register space
  typedef logic [`EX_RF_AW-1:0] rf_addr_t;

endpackage

// ==== src/ex_op_pkg.sv ====
package ex_op_pkg;

  // ALU operations
  // The six branch compares sit in the upper half of the code space
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operations
  // MUL returns the low word, the others the high word
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

  // Branch compare opcodes drive the comparison output
  function automatic logic alu_is_cmp(alu_op_e op);
    return op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  endfunction

  // High-word variants take the iterative path
  function automatic logic mul_is_high(mul_op_e op);
    return op != MUL_MUL;
  endfunction

endpackage

// ==== src/ex_unit_if.sv ====
`timescale 1ns/100ps

// Request and result bundle between the execute stage and one functional unit
// The opcode type differs per unit, the data words are shared
interface ex_unit_if
  import ex_rf_pkg::*;
#(
  parameter type op_t = logic [3:0]
);

  // Request is a level, held by decode while the instruction sits in EX
  logic  enable;
  op_t   operator;
  word_t operand_a;
  word_t operand_b;

  // Result of the unit
  // Single-cycle units answer in the same cycle
  // Multicycle units qualify it with their own ready level
  word_t result;

  // Stage side issues the request and picks up the result
  modport stage (
    output enable,
    output operator,
    output operand_a,
    output operand_b,
    input  result
  );

  // Unit side consumes the request
  modport unit (
    input  enable,
    input  operator,
    input  operand_a,
    input  operand_b,
    output result
  );

endinterface

// ==== src/ex_alu.sv ====
`timescale 1ns/100ps

`include "ex_config.svh"

module ex_alu
  import ex_rf_pkg::*;
  import ex_op_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  ex_unit_if.unit bus,

  // Branch decision towards fetch
  output logic cmp_o
);

  localparam int XW  = `EX_XLEN;
  localparam int SHW = $clog2(`EX_XLEN);

  logic           eq;
  logic           lt_s;
  logic           lt_u;
  logic [SHW-1:0] shamt;
  word_t          alu_res;

  ////////////////////////////////////////////////////////////////////////////
  // Comparisons
  ////////////////////////////////////////////////////////////////////////////

  // Shared by set-less-than and the branch compares
  assign eq   = (bus.operand_a == bus.operand_b);
  assign lt_s = ($signed(bus.operand_a) < $signed(bus.operand_b));
  assign lt_u = (bus.operand_a < bus.operand_b);

  always_comb begin
    case (bus.operator)
      ALU_EQ:  cmp_o = eq;
      ALU_NE:  cmp_o = ~eq;
      ALU_LT:  cmp_o = lt_s;
      ALU_GE:  cmp_o = ~lt_s;
      ALU_LTU: cmp_o = lt_u;
      ALU_GEU: cmp_o = ~lt_u;
      // Not a branch, never taken
      default: cmp_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  // Only the low bits of operand b count for shifts
  assign shamt = bus.operand_b[SHW-1:0];

  always_comb begin
    case (bus.operator)
      ALU_ADD:  alu_res = bus.operand_a + bus.operand_b;
      ALU_SUB:  alu_res = bus.operand_a - bus.operand_b;
      ALU_AND:  alu_res = bus.operand_a & bus.operand_b;
      ALU_OR:   alu_res = bus.operand_a | bus.operand_b;
      ALU_XOR:  alu_res = bus.operand_a ^ bus.operand_b;
      ALU_SLL:  alu_res = bus.operand_a << shamt;
      ALU_SRL:  alu_res = bus.operand_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  alu_res = word_t'($signed(bus.operand_a) >>> shamt);
      ALU_SLT:  alu_res = {{(XW-1){1'b0}}, lt_s};
      ALU_SLTU: alu_res = {{(XW-1){1'b0}}, lt_u};
      // Branch compares return the decision zero-extended
      default:  alu_res = {{(XW-1){1'b0}}, cmp_o};
    endcase
  end

  assign bus.result = alu_res;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Decode must hand over a known opcode with every request
  a_op_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    bus.enable |-> !$isunknown(bus.operator)
  );

  // A compare writes back a single flag, upper bits stay clear
  a_cmp_flag : assert property (
    @(posedge clk) disable iff (!rst_n)
    (bus.enable && alu_is_cmp(bus.operator)) |-> (bus.result[XW-1:1] == '0)
  );

endmodule

// ==== src/ex_mult.sv ====
`timescale 1ns/100ps

`include "ex_config.svh"

module ex_mult
  import ex_rf_pkg::*;
  import ex_op_pkg::*;
(
  input  logic clk,
  input  logic rst_n,

  ex_unit_if.unit bus,

  // Stage accepts the result
  input  logic ex_ready_i,

  output logic ready_o,
  output logic multicycle_o
);

  localparam int XW    = `EX_XLEN;
  localparam int HW    = `EX_PP_W;
  localparam int CNT_W = $clog2(`EX_MULH_CYCLES);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`EX_MULH_CYCLES - 1);

  typedef enum logic [1:0] {M_IDLE, M_STEP, M_HOLD} mult_state_e;

  mult_state_e           state_q;
  logic [CNT_W-1:0]      cnt_q;
  dword_t                acc_q;
  dword_t                acc_next;
  dword_t                pp_ext;
  logic                  sign_a;
  logic                  sign_b;
  logic signed [HW:0]    pp_a;
  logic signed [HW:0]    pp_b;
  logic signed [2*HW+1:0] pp;
  logic                  start;
  word_t                 prod_lo;

  ////////////////////////////////////////////////////////////////////////////
  // Partial products
  ////////////////////////////////////////////////////////////////////////////

  // Low word is the same for every signedness
  assign prod_lo = bus.operand_a * bus.operand_b;

  always_comb begin
    sign_a = (bus.operator == MUL_MULH) || (bus.operator == MUL_MULHSU);
    sign_b = (bus.operator == MUL_MULH);
    // Upper halves carry the sign, lower halves are always unsigned
    pp_a = cnt_q[1] ? {sign_a & bus.operand_a[XW-1], bus.operand_a[XW-1:HW]}
                    : {1'b0, bus.operand_a[HW-1:0]};
    pp_b = cnt_q[0] ? {sign_b & bus.operand_b[XW-1], bus.operand_b[XW-1:HW]}
                    : {1'b0, bus.operand_b[HW-1:0]};
    pp   = pp_a * pp_b;
    // Sign-extend to the product width and align by the half positions
    pp_ext = {{(2*XW-2*HW-2){pp[2*HW+1]}}, pp} << (HW * (cnt_q[0] + cnt_q[1]));
    // Idle starts a fresh sum, hold adds nothing
    acc_next = (state_q == M_IDLE) ? pp_ext
             : (state_q == M_HOLD) ? acc_q
             : acc_q + pp_ext;
  end

  assign start = bus.enable && mul_is_high(bus.operator);

  ////////////////////////////////////////////////////////////////////////////
  // High-word FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= M_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        M_IDLE: begin
          if (start) begin
            state_q <= M_STEP;
            cnt_q   <= cnt_q + 1'b1;
          end
        end
        M_STEP: begin
          if (cnt_q != LAST) begin
            cnt_q <= cnt_q + 1'b1;
          end else begin
            cnt_q   <= '0;
            // Keep the finished word if the stage stalls
            state_q <= ex_ready_i ? M_IDLE : M_HOLD;
          end
        end
        default: begin
          if (ex_ready_i) begin
            state_q <= M_IDLE;
          end
        end
      endcase
    end
  end

  // Running sum, meaningful only while a high-word multiply is in flight
  always_ff @(posedge clk) begin
    if (start || (state_q != M_IDLE)) begin
      acc_q <= acc_next;
    end
  end

  // Last step or holding
  assign multicycle_o = ((state_q == M_STEP) && (cnt_q == LAST)) || (state_q == M_HOLD);

  // Low at the first cycle of a high-word request, then until the last step
  assign ready_o = (state_q == M_IDLE) ? !start : multicycle_o;

  assign bus.result = (bus.operator == MUL_MUL) ? prod_lo : acc_next[2*XW-1:XW];

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_ready_returns : assert property (
    @(posedge clk) disable iff (!rst_n)
    !ready_o |-> ##[1:`EX_MULH_CYCLES] ready_o
  );

  // Partial products are taken from the live opcode
  a_op_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q != M_IDLE) |-> $stable(bus.operator)
  );

endmodule

// ==== src/ex_writeback.sv ====
`timescale 1ns/100ps

module ex_writeback
  import ex_rf_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // Result sources of the ALU write port
  input  logic     alu_en_i,
  input  logic     mult_en_i,
  input  logic     csr_access_i,
  input  word_t    alu_result_i,
  input  word_t    mult_result_i,
  input  word_t    csr_rdata_i,
  input  logic     regfile_alu_we_i,
  input  rf_addr_t regfile_alu_waddr_i,

  // Forwarding towards ID and the register file
  output logic     regfile_alu_we_fw_o,
  output rf_addr_t regfile_alu_waddr_fw_o,
  output word_t    regfile_alu_wdata_fw_o,

  // LSU write port into WB
  input  logic     ex_valid_i,
  input  logic     wb_ready_i,
  input  logic     regfile_we_i,
  input  logic     lsu_err_i,
  input  rf_addr_t regfile_waddr_i,
  input  word_t    lsu_rdata_i,

  output logic     regfile_we_wb_o,
  output rf_addr_t regfile_waddr_wb_o,
  output word_t    regfile_wdata_wb_o
);

  ////////////////////////////////////////////////////////////////////////////
  // ALU write port mux
  ////////////////////////////////////////////////////////////////////////////

  // Decode owns enable and address
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR read wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o <= 1'b0;
    end else if (ex_valid_i) begin
      // Faulting load must not reach the register file
      regfile_we_wb_o <= regfile_we_i & ~lsu_err_i;
    end else if (wb_ready_i) begin
      // WB drains with nothing new behind it
      regfile_we_wb_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i) begin
      regfile_waddr_wb_o <= regfile_waddr_i;
    end
  end

  // Load data arrives in WB directly from the LSU
  assign regfile_wdata_wb_o = lsu_rdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_we_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(regfile_we_wb_o)
  );

endmodule

// ==== src/ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage
  import ex_rf_pkg::*;
  import ex_op_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // ALU request from ID
  input  alu_op_e  alu_operator_i,
  input  word_t    alu_operand_a_i,
  input  word_t    alu_operand_b_i,
  input  word_t    alu_operand_c_i,
  input  logic     alu_en_i,

  // Multiplier request from ID
  input  mul_op_e  mult_operator_i,
  input  word_t    mult_operand_a_i,
  input  word_t    mult_operand_b_i,
  input  logic     mult_en_i,
  output logic     mult_multicycle_o,

  // CSR and LSU
  input  logic     csr_access_i,
  input  word_t    csr_rdata_i,
  input  logic     lsu_en_i,
  input  word_t    lsu_rdata_i,
  input  logic     lsu_ready_ex_i,
  input  logic     lsu_err_i,

  // Register writes from decode
  input  logic     regfile_alu_we_i,
  input  rf_addr_t regfile_alu_waddr_i,
  input  logic     regfile_we_i,
  input  rf_addr_t regfile_waddr_i,

  input  logic     branch_in_ex_i,
  input  logic     wb_ready_i,

  // Forwarding port
  output logic     regfile_alu_we_fw_o,
  output rf_addr_t regfile_alu_waddr_fw_o,
  output word_t    regfile_alu_wdata_fw_o,

  // LSU write-back port
  output logic     regfile_we_wb_o,
  output rf_addr_t regfile_waddr_wb_o,
  output word_t    regfile_wdata_wb_o,

  // To IF
  output word_t    jump_target_o,
  output logic     branch_decision_o,

  output logic     ex_ready_o,
  output logic     ex_valid_o
);

  logic alu_cmp;
  logic mult_ready;

  ex_unit_if #(.op_t(alu_op_e)) alu_bus ();
  ex_unit_if #(.op_t(mul_op_e)) mul_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////////////////////

  assign alu_bus.enable    = alu_en_i;
  assign alu_bus.operator  = alu_operator_i;
  assign alu_bus.operand_a = alu_operand_a_i;
  assign alu_bus.operand_b = alu_operand_b_i;

  assign mul_bus.enable    = mult_en_i;
  assign mul_bus.operator  = mult_operator_i;
  assign mul_bus.operand_a = mult_operand_a_i;
  assign mul_bus.operand_b = mult_operand_b_i;

  ex_alu alu_i (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (alu_bus.unit),
    .cmp_o (alu_cmp)
  );

  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus          (mul_bus.unit),
    .ex_ready_i   (ex_ready_o),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback wb_i (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .alu_result_i           (alu_bus.result),
    .mult_result_i          (mul_bus.result),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .ex_valid_i             (ex_valid_o),
    .wb_ready_i             (wb_ready_i),
    .regfile_we_i           (regfile_we_i),
    .lsu_err_i              (lsu_err_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Branch and stall control
  ////////////////////////////////////////////////////////////////////////////

  // Target is computed in ID, only the decision comes from EX
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = alu_cmp;

  // Branches complete here without WB, so they bypass the stall
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;

  // Valid does not look at ready, avoids a loop through ID
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                    & (mult_ready & lsu_ready_ex_i & wb_ready_i);

endmodule

// ==== dv/ex_stage_checker.sv ====
`timescale 1ns/100ps

`include "ex_config.svh"

module ex_stage_checker
  import ex_rf_pkg::*;
  import ex_op_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  alu_op_e  alu_operator_i,
  input  word_t    alu_operand_a_i,
  input  word_t    alu_operand_b_i,
  input  word_t    alu_operand_c_i,
  input  logic     alu_en_i,
  input  mul_op_e  mult_operator_i,
  input  word_t    mult_operand_a_i,
  input  word_t    mult_operand_b_i,
  input  logic     mult_en_i,
  input  logic     mult_multicycle_o,
  input  logic     csr_access_i,
  input  word_t    csr_rdata_i,
  input  logic     lsu_en_i,
  input  word_t    lsu_rdata_i,
  input  logic     lsu_ready_ex_i,
  input  logic     lsu_err_i,
  input  logic     regfile_alu_we_i,
  input  rf_addr_t regfile_alu_waddr_i,
  input  logic     regfile_we_i,
  input  rf_addr_t regfile_waddr_i,
  input  logic     branch_in_ex_i,
  input  logic     wb_ready_i,
  input  logic     regfile_alu_we_fw_o,
  input  rf_addr_t regfile_alu_waddr_fw_o,
  input  word_t    regfile_alu_wdata_fw_o,
  input  logic     regfile_we_wb_o,
  input  rf_addr_t regfile_waddr_wb_o,
  input  word_t    regfile_wdata_wb_o,
  input  word_t    jump_target_o,
  input  logic     branch_decision_o,
  input  logic     ex_ready_o,
  input  logic     ex_valid_o,
  // Test sequencing from the testbench top
  input  int       test_num,
  output int       chk_total,
  output int       err_total
);

  localparam int XW   = `EX_XLEN;
  localparam int SHW  = $clog2(`EX_XLEN);
  localparam int LAST = `EX_MULH_CYCLES - 1;

  // Model of the high-word multiply occupancy, 0 is idle
  int       mstep = 0;
  logic     start;
  logic     mready;
  logic     rdy_exp;
  logic     vld_exp;
  logic     fw_check;
  word_t    fw_exp;
  // Model of the EX/WB register
  logic     we_exp;
  rf_addr_t waddr_exp;
  logic     addr_known;
  int       cur_test = 0;
  int       test_chk = 0;
  int       test_err = 0;
  int       n_chk = 0;
  int       n_err = 0;

  assign chk_total = n_chk;
  assign err_total = n_err;

  ////////////////////////////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic branch_taken(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_result_of(alu_op_e op, word_t a, word_t b);
    logic [SHW-1:0] sh;
    sh = b[SHW-1:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return word_t'($signed(a) >>> sh);
      ALU_SLT:  return word_t'($signed(a) < $signed(b));
      ALU_SLTU: return word_t'(a < b);
      // Compares write the flag zero-extended
      default:  return word_t'(branch_taken(op, a, b));
    endcase
  endfunction

  // Full 64-bit product of the extended operands, then pick the word
  function automatic word_t product_word(mul_op_e op, word_t a, word_t b);
    dword_t xa;
    dword_t xb;
    dword_t p;
    xa = (op == MUL_MULH || op == MUL_MULHSU) ? {{XW{a[XW-1]}}, a} : {{XW{1'b0}}, a};
    xb = (op == MUL_MULH) ? {{XW{b[XW-1]}}, b} : {{XW{1'b0}}, b};
    p  = xa * xb;
    return (op == MUL_MUL) ? p[XW-1:0] : p[2*XW-1:XW];
  endfunction

  function automatic string test_name(int n);
    case (n)
      1:       return "alu operations";
      2:       return "branch compares";
      3:       return "multiplier";
      4:       return "forwarding priority";
      5:       return "lsu write-back";
      6:       return "back-pressure";
      default: return "unknown";
    endcase
  endfunction

  task automatic expect_eq(string name, word_t exp, word_t act);
    n_chk++;
    test_chk++;
    if (exp !== act) begin
      n_err++;
      test_err++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Comparison, one pass per rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    // New test number closes the previous test
    if (test_num != cur_test) begin
      if (cur_test != 0) begin
        $display("test %0d (%s): %0d checks, %0d errors, %s", cur_test,
                 test_name(cur_test), test_chk, test_err, (test_err == 0) ? "ok" : "FAILED");
      end
      cur_test = test_num;
      test_chk = 0;
      test_err = 0;
    end
    if (!rst_n) begin
      mstep      = 0;
      we_exp     = 1'b0;
      addr_known = 1'b0;
    end else begin
      // Multiplier ready, low from the first cycle of a high-word request
      start   = mult_en_i && (mult_operator_i != MUL_MUL);
      mready  = (mstep == 0) ? !start : (mstep == LAST);
      rdy_exp = (mready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
      vld_exp = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
              & mready & lsu_ready_ex_i & wb_ready_i;
      expect_eq("ex_ready_o", word_t'(rdy_exp), word_t'(ex_ready_o));
      expect_eq("ex_valid_o", word_t'(vld_exp), word_t'(ex_valid_o));
      expect_eq("mult_multicycle_o", word_t'(mstep == LAST), word_t'(mult_multicycle_o));

      // Forwarding mux, CSR over multiplier over ALU
      fw_check = 1'b1;
      if (csr_access_i) begin
        fw_exp = csr_rdata_i;
      end else if (mult_en_i) begin
        fw_exp   = product_word(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
        fw_check = mready;
      end else if (alu_en_i) begin
        fw_exp = alu_result_of(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
      end else begin
        fw_check = 1'b0;
      end
      if (fw_check) begin
        expect_eq("regfile_alu_wdata_fw_o", fw_exp, regfile_alu_wdata_fw_o);
      end
      expect_eq("regfile_alu_we_fw_o", word_t'(regfile_alu_we_i), word_t'(regfile_alu_we_fw_o));
      expect_eq("regfile_alu_waddr_fw_o", word_t'(regfile_alu_waddr_i),
                word_t'(regfile_alu_waddr_fw_o));

      // Branch outputs
      expect_eq("branch_decision_o",
                word_t'(branch_taken(alu_operator_i, alu_operand_a_i, alu_operand_b_i)),
                word_t'(branch_decision_o));
      expect_eq("jump_target_o", alu_operand_c_i, jump_target_o);

      // EX/WB register as captured at the previous edge
      expect_eq("regfile_we_wb_o", word_t'(we_exp), word_t'(regfile_we_wb_o));
      if (addr_known) begin
        expect_eq("regfile_waddr_wb_o", word_t'(waddr_exp), word_t'(regfile_waddr_wb_o));
      end
      expect_eq("regfile_wdata_wb_o", lsu_rdata_i, regfile_wdata_wb_o);

      // Advance the models
      if (vld_exp) begin
        we_exp     = regfile_we_i & ~lsu_err_i;
        waddr_exp  = regfile_waddr_i;
        addr_known = 1'b1;
      end else if (wb_ready_i) begin
        we_exp = 1'b0;
      end
      if (mstep == 0) begin
        if (start) begin
          mstep = 1;
        end
      end else if (mstep != LAST) begin
        mstep = mstep + 1;
      end else if (rdy_exp) begin
        // Finished word is kept until the stage accepts it
        mstep = 0;
      end
    end
  end

endmodule

// ==== dv/ex_stage_tb.sv ====
`timescale 1ns/100ps

`include "ex_config.svh"

module ex_stage_tb
  import ex_rf_pkg::*;
  import ex_op_pkg::*;
();

  localparam int   CLK_PERIOD = 4;
  localparam int   RST_CYCLES = 5;
  localparam word_t SEED      = 32'h2d40_440c;
  localparam int   N_ALU  = 200;
  localparam int   N_CMP  = 100;
  localparam int   N_MUL  = 120;
  localparam int   N_PRIO = 100;
  localparam int   N_WB   = 150;
  localparam int   N_BP   = 150;
  localparam int   TOTAL_OPS = N_ALU + N_CMP + N_MUL + N_PRIO + N_WB + N_BP;
  // Every operation gets the length of a high-word multiply plus slack
  localparam int   WATCHDOG_CYCLES = TOTAL_OPS * `EX_MULH_CYCLES + 200;
  // Longest wait for one multiply including an injected write-back stall
  localparam int   MULT_WAIT = `EX_MULH_CYCLES + 12;

  logic     clk, rst_n;
  alu_op_e  alu_operator_i;
  word_t    alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  logic     alu_en_i;
  mul_op_e  mult_operator_i;
  word_t    mult_operand_a_i, mult_operand_b_i;
  logic     mult_en_i, mult_multicycle_o;
  logic     csr_access_i, lsu_en_i, lsu_ready_ex_i, lsu_err_i;
  word_t    csr_rdata_i, lsu_rdata_i;
  logic     regfile_alu_we_i, regfile_we_i;
  rf_addr_t regfile_alu_waddr_i, regfile_waddr_i;
  logic     branch_in_ex_i, wb_ready_i;
  logic     regfile_alu_we_fw_o, regfile_we_wb_o;
  rf_addr_t regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  word_t    regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;
  logic     branch_decision_o, ex_ready_o, ex_valid_o;

  int       test_num = 0;
  int       chk_total;
  int       err_total;
  int       tb_err = 0;
  word_t    rng = SEED;

  ex_stage ex_stage_i (.*);

  ex_stage_checker checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // LCG with the common 32-bit constants
  function automatic word_t next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  // No request, no stall, fresh data words
  task automatic set_idle();
    alu_en_i            = 1'b0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    lsu_en_i            = 1'b0;
    lsu_err_i           = 1'b0;
    lsu_ready_ex_i      = 1'b1;
    wb_ready_i          = 1'b1;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_we_i        = 1'b0;
    alu_operator_i      = ALU_ADD;
    mult_operator_i     = MUL_MUL;
    alu_operand_a_i     = next_rand();
    alu_operand_b_i     = next_rand();
    alu_operand_c_i     = next_rand();
    mult_operand_a_i    = next_rand();
    mult_operand_b_i    = next_rand();
    csr_rdata_i         = next_rand();
    lsu_rdata_i         = next_rand();
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
  endtask

  // Random ALU requests or only the branch compares
  task automatic run_alu(input int n, input logic cmp_only);
    word_t r;
    repeat (n) begin
      set_idle();
      r = next_rand();
      alu_en_i            = 1'b1;
      alu_operator_i      = cmp_only ? alu_op_e'(4'd10 + 4'(r[31:24] % 8'd6))
                                     : alu_op_e'(r[31:28]);
      // Equal operands now and then so EQ and GE get taken
      alu_operand_b_i     = r[23] ? alu_operand_a_i : alu_operand_b_i;
      regfile_alu_we_i    = r[22];
      regfile_alu_waddr_i = r[21:16];
      @(negedge clk);
    end
  endtask

  // Each multiply is held until the stage accepts it
  task automatic run_mult(input int n);
    word_t r;
    int    stall;
    int    waited;
    repeat (n) begin
      set_idle();
      r = next_rand();
      stall               = int'(r[31:29]);
      mult_en_i           = 1'b1;
      mult_operator_i     = mul_op_e'(r[28:27]);
      regfile_alu_we_i    = 1'b1;
      regfile_alu_waddr_i = r[21:16];
      // Write-back stall over the first cycles of the request
      wb_ready_i          = (stall == 0);
      waited              = 0;
      @(posedge clk);
      while (!ex_ready_o && waited < MULT_WAIT) begin
        waited++;
        if (waited >= stall) begin
          @(negedge clk);
          wb_ready_i = 1'b1;
        end
        @(posedge clk);
      end
      if (!ex_ready_o) begin
        tb_err++;
        $display("multiply was not accepted within %0d cycles at %0t", MULT_WAIT, $time);
      end
      @(negedge clk);
    end
  endtask

  // Several sources at once with a single-cycle multiply only
  task automatic run_prio(input int n);
    word_t r;
    repeat (n) begin
      set_idle();
      r = next_rand();
      alu_en_i         = r[31];
      mult_en_i        = r[30];
      csr_access_i     = r[29];
      alu_operator_i   = alu_op_e'(r[27:24]);
      regfile_alu_we_i = r[23];
      @(negedge clk);
    end
  endtask

  // LSU writes mixed with idle cycles and optional back-pressure
  task automatic run_lsu(input int n, input logic stall);
    word_t r;
    logic  busy;
    repeat (n) begin
      set_idle();
      r = next_rand();
      busy            = (r[31:30] != 2'b00);
      lsu_en_i        = busy & r[29];
      alu_en_i        = busy & ~r[29];
      csr_access_i    = busy & r[28] & r[27];
      regfile_we_i    = r[26];
      lsu_err_i       = r[25] & r[24];
      regfile_waddr_i = r[23:18];
      alu_operator_i  = alu_op_e'(r[17:14]);
      if (stall) begin
        wb_ready_i     = r[13] & r[12];
        branch_in_ex_i = r[11];
        lsu_ready_ex_i = r[10] | r[9];
      end
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    set_idle();
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_num = 1;
    run_alu(N_ALU, 1'b0);
    test_num = 2;
    run_alu(N_CMP, 1'b1);
    test_num = 3;
    run_mult(N_MUL);
    test_num = 4;
    run_prio(N_PRIO);
    test_num = 5;
    run_lsu(N_WB, 1'b0);
    test_num = 6;
    run_lsu(N_BP, 1'b1);

    // Checker closes the last test at the next edge
    set_idle();
    test_num = 0;
    @(negedge clk);
    $display("summary: %0d checks, %0d errors", chk_total, err_total + tb_err);
    if (err_total + tb_err == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== ex_stage.f ====
+incdir+src
src/ex_rf_pkg.sv
src/ex_op_pkg.sv
src/ex_unit_if.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_writeback.sv
src/ex_stage.sv
dv/ex_stage_checker.sv
dv/ex_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard src/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
